//--- common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// instruction buffer geometry
`define IQ_FETCH_WIDTH 4   // fetch slots per cycle, one fifo channel each
`define IQ_DEPTH       8   // entries per channel, power of two

`endif

//--- common/instr_pkg.sv
package instr_pkg;

	// architectural widths of one buffered instruction
	localparam int unsigned XLEN = 32;
	localparam int unsigned ILEN = 32;

	// entry handed from fetch through the queue to decode, 65 bits
	typedef struct packed {
		logic [XLEN-1:0] pc;          // fetch address
		logic [ILEN-1:0] instr;       // raw encoding
		logic            pred_taken;  // branch predictor verdict
	} instr_entry_t;

endpackage

//--- common/iq_csr_pkg.sv
package iq_csr_pkg;

	// register bus geometry
	localparam int unsigned IQ_ADDR_W = 4;
	localparam int unsigned IQ_DATA_W = 32;

	// register map
	localparam logic [IQ_ADDR_W-1:0] IQ_ADDR_CTRL   = 4'h0;  // issue limit, flush request
	localparam logic [IQ_ADDR_W-1:0] IQ_ADDR_STATUS = 4'h4;  // occupancy, read only

	// ctrl fields
	localparam int unsigned IQ_LIMIT_W        = 3;
	localparam int unsigned IQ_CTRL_FLUSH_BIT = 31;

	// configuration seen by the datapath
	typedef struct packed {
		logic [IQ_LIMIT_W-1:0] issue_limit;  // 0 selects the full fetch width
		logic                  flush;        // single cycle pulse
	} iq_cfg_t;

endpackage

//--- rtl/fifo_v3.sv
`timescale 1ns/1ps

module fifo_v3 #(
	parameter int unsigned DEPTH = 8,             // power of two, at least 2
	parameter type         dtype = logic [31:0]
)(
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	output logic full_o,
	output logic empty_o,
	input  dtype data_i,
	input  logic push_i,
	output dtype data_o,
	input  logic pop_i
);

	localparam int unsigned ADDR_W = $clog2(DEPTH);

	logic [ADDR_W:0] wr_ptr_q;  // top bit flips on each wrap
	logic [ADDR_W:0] rd_ptr_q;
	dtype            mem_q [DEPTH];

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
	                 (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

	// head entry falls through without a read cycle
	assign data_o = mem_q[rd_ptr_q[ADDR_W-1:0]];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && !flush_i) begin
			mem_q[wr_ptr_q[ADDR_W-1:0]] <= data_i;
		end
	end

	// the banked queue's free-space rule must keep full channels out of a push
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push_i && !flush_i |-> !full_o)
		else $error("fifo_v3: push into full channel");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop_i && !flush_i |-> !empty_o)
		else $error("fifo_v3: pop from empty channel");

endmodule

//--- instr_queue/multi_queue.sv
`timescale 1ns/1ps

module multi_queue #(
	parameter int unsigned  FETCH_WIDTH = 4,
	parameter int unsigned  DEPTH       = 8,
	parameter type          dtype       = logic [31:0],
	localparam int unsigned IDX_W       = $clog2(FETCH_WIDTH + 1),
	localparam int unsigned CAP         = FETCH_WIDTH * DEPTH,
	localparam int unsigned CNT_W       = $clog2(CAP + 1)
)(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   flush_i,
	input  dtype [FETCH_WIDTH-1:0] push_data_i,  // compacted, slot 0 first
	input  logic [IDX_W-1:0]       push_num_i,
	output dtype [FETCH_WIDTH-1:0] pop_data_o,   // oldest entry in slot 0
	input  logic [IDX_W-1:0]       pop_num_i,
	output logic [CNT_W-1:0]       count_o
);

	logic [IDX_W-1:0]       wr_ptr_q;  // channel taking the next write
	logic [IDX_W-1:0]       rd_ptr_q;  // channel holding the oldest entry
	logic [FETCH_WIDTH-1:0] ch_push;
	logic [FETCH_WIDTH-1:0] ch_pop;
	logic [FETCH_WIDTH-1:0] ch_full;
	logic [FETCH_WIDTH-1:0] ch_empty;
	dtype [FETCH_WIDTH-1:0] ch_din;
	dtype [FETCH_WIDTH-1:0] ch_dout;

	// reduce a value below 2*FETCH_WIDTH into a channel number
	function automatic logic [IDX_W-1:0] wrap(input logic [IDX_W:0] v);
		return (v >= FETCH_WIDTH) ? IDX_W'(v - FETCH_WIDTH) : IDX_W'(v);
	endfunction

	for (genvar c = 0; c < FETCH_WIDTH; c++) begin : gen_chan
		logic [IDX_W-1:0] wr_slot;  // bundle slot landing in this channel
		logic [IDX_W-1:0] rd_slot;

		assign wr_slot = wrap((IDX_W+1)'(c + FETCH_WIDTH - wr_ptr_q));
		assign rd_slot = wrap((IDX_W+1)'(c + FETCH_WIDTH - rd_ptr_q));

		assign ch_push[c] = (wr_slot < push_num_i);
		assign ch_pop[c]  = (rd_slot < pop_num_i);
		assign ch_din[c]  = push_data_i[wr_slot];

		// rotate the heads back into age order
		assign pop_data_o[c] = ch_dout[wrap((IDX_W+1)'(rd_ptr_q + c))];

		fifo_v3 #(
			.DEPTH   ( DEPTH ),
			.dtype   ( dtype )
		) u_fifo (
			.clk     ( clk         ),
			.rst_n   ( rst_n       ),
			.flush_i ( flush_i     ),
			.full_o  ( ch_full[c]  ),
			.empty_o ( ch_empty[c] ),
			.data_i  ( ch_din[c]   ),
			.push_i  ( ch_push[c]  ),
			.data_o  ( ch_dout[c]  ),
			.pop_i   ( ch_pop[c]   )
		);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_o  <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_o  <= '0;
		end else begin
			wr_ptr_q <= wrap({1'b0, wr_ptr_q} + push_num_i);
			rd_ptr_q <= wrap({1'b0, rd_ptr_q} + pop_num_i);
			count_o  <= count_o + CNT_W'(push_num_i) - CNT_W'(pop_num_i);
		end
	end

	a_pop_le_count: assert property (@(posedge clk) disable iff (!rst_n)
		CNT_W'(pop_num_i) <= count_o)
		else $error("multi_queue: pop of %0d with count %0d", pop_num_i, count_o);

	// count agrees with the channels: empty means every fifo drained
	a_count_cap: assert property (@(posedge clk) disable iff (!rst_n)
		(count_o <= CAP) && ((count_o == '0) == (&ch_empty)))
		else $error("multi_queue: count %0d out of step with channels", count_o);

	a_full_means_cap: assert property (@(posedge clk) disable iff (!rst_n)
		(&ch_full) |-> (count_o == CAP))
		else $error("multi_queue: all channels full below capacity");

endmodule

//--- instr_queue/iq_regs.sv
`timescale 1ns/1ps

module iq_regs import iq_csr_pkg::*; #(
	parameter int unsigned  FETCH_WIDTH = 4,
	parameter int unsigned  DEPTH       = 8,
	localparam int unsigned CNT_W       = $clog2(FETCH_WIDTH * DEPTH + 1)
)(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 reg_we_i,
	input  logic [IQ_ADDR_W-1:0] reg_addr_i,
	input  logic [IQ_DATA_W-1:0] reg_wdata_i,
	output logic [IQ_DATA_W-1:0] reg_rdata_o,
	input  logic                 flush_i,     // branch mispredict
	input  logic [CNT_W-1:0]     count_i,
	output iq_cfg_t              cfg_o
);

	logic [IQ_LIMIT_W-1:0] limit_q;
	logic                  flush_q;  // software flush, one cycle after the write
	logic                  ctrl_wr;

	assign ctrl_wr = reg_we_i && (reg_addr_i == IQ_ADDR_CTRL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			limit_q <= '0;
			flush_q <= 1'b0;
		end else begin
			flush_q <= ctrl_wr && reg_wdata_i[IQ_CTRL_FLUSH_BIT];
			if (ctrl_wr) begin
				limit_q <= reg_wdata_i[IQ_LIMIT_W-1:0];
			end
		end
	end

	assign cfg_o.issue_limit = limit_q;
	assign cfg_o.flush       = flush_q | flush_i;

	// status is read only, writes there fall through
	always_comb begin
		reg_rdata_o = '0;
		case (reg_addr_i)
			IQ_ADDR_CTRL:   reg_rdata_o = IQ_DATA_W'(limit_q);
			IQ_ADDR_STATUS: reg_rdata_o = IQ_DATA_W'(count_i);
			default:        reg_rdata_o = '0;
		endcase
	end

endmodule

//--- rtl/fetch_packer.sv
`timescale 1ns/1ps

module fetch_packer import instr_pkg::*; #(
	parameter int unsigned  FETCH_WIDTH = 4,
	parameter int unsigned  DEPTH       = 8,
	localparam int unsigned IDX_W       = $clog2(FETCH_WIDTH + 1),
	localparam int unsigned CAP         = FETCH_WIDTH * DEPTH,
	localparam int unsigned CNT_W       = $clog2(CAP + 1)
)(
	input  instr_entry_t [FETCH_WIDTH-1:0] fetch_bundle_i,
	input  logic [FETCH_WIDTH-1:0]         fetch_mask_i,
	input  logic                           fetch_valid_i,
	input  logic [CNT_W-1:0]               count_i,
	output logic                           fetch_ready_o,
	output instr_entry_t [FETCH_WIDTH-1:0] push_data_o,
	output logic [IDX_W-1:0]               push_num_o
);

	logic [IDX_W-1:0] mask_cnt;
	logic [CNT_W-1:0] free_space;

	// squeeze valid slots down, keeping program order
	always_comb begin
		logic [IDX_W-1:0] wr_idx;

		wr_idx      = '0;
		push_data_o = '0;
		for (int i = 0; i < FETCH_WIDTH; i++) begin
			if (fetch_mask_i[i]) begin
				push_data_o[wr_idx] = fetch_bundle_i[i];
				wr_idx              = wr_idx + 1'b1;
			end
		end
		mask_cnt = wr_idx;
	end

	// same-cycle pops are not credited
	assign free_space    = CNT_W'(CAP) - count_i;
	assign fetch_ready_o = (free_space >= CNT_W'(mask_cnt));
	assign push_num_o    = (fetch_valid_i && fetch_ready_o) ? mask_cnt : '0;

endmodule

//--- rtl/decode_dispatch.sv
`timescale 1ns/1ps

module decode_dispatch import instr_pkg::*; import iq_csr_pkg::*; #(
	parameter int unsigned  FETCH_WIDTH = 4,
	parameter int unsigned  DEPTH       = 8,
	localparam int unsigned IDX_W       = $clog2(FETCH_WIDTH + 1),
	localparam int unsigned CNT_W       = $clog2(FETCH_WIDTH * DEPTH + 1)
)(
	input  instr_entry_t [FETCH_WIDTH-1:0] pop_data_i,   // oldest first
	input  logic [CNT_W-1:0]               count_i,
	input  iq_cfg_t                        cfg_i,
	input  logic [IDX_W-1:0]               dec_take_i,
	output instr_entry_t [FETCH_WIDTH-1:0] dec_bundle_o,
	output logic [FETCH_WIDTH-1:0]         dec_valid_o,
	output logic [IDX_W-1:0]               pop_num_o
);

	logic [IDX_W-1:0] eff_limit;
	logic [IDX_W-1:0] offered;  // entries shown to decode this cycle

	always_comb begin
		// zero or an oversized limit both mean the whole width
		if (cfg_i.issue_limit == '0 || cfg_i.issue_limit > FETCH_WIDTH) begin
			eff_limit = IDX_W'(FETCH_WIDTH);
		end else begin
			eff_limit = IDX_W'(cfg_i.issue_limit);
		end
		offered = (count_i < CNT_W'(eff_limit)) ? IDX_W'(count_i) : eff_limit;
	end

	for (genvar i = 0; i < FETCH_WIDTH; i++) begin : gen_valid
		assign dec_valid_o[i] = (i < offered);
	end

	assign dec_bundle_o = pop_data_i;
	assign pop_num_o    = (dec_take_i < offered) ? dec_take_i : offered;  // clip to offer

endmodule

//--- rtl/instr_buffer_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instr_buffer_top import instr_pkg::*; import iq_csr_pkg::*; #(
	parameter int unsigned  FETCH_WIDTH = `IQ_FETCH_WIDTH,
	parameter int unsigned  DEPTH       = `IQ_DEPTH,
	localparam int unsigned IDX_W       = $clog2(FETCH_WIDTH + 1)
)(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           flush_i,
	input  instr_entry_t [FETCH_WIDTH-1:0] fetch_bundle_i,
	input  logic [FETCH_WIDTH-1:0]         fetch_mask_i,
	input  logic                           fetch_valid_i,
	output logic                           fetch_ready_o,
	output instr_entry_t [FETCH_WIDTH-1:0] dec_bundle_o,
	output logic [FETCH_WIDTH-1:0]         dec_valid_o,
	input  logic [IDX_W-1:0]               dec_take_i,
	input  logic                           reg_we_i,
	input  logic [IQ_ADDR_W-1:0]           reg_addr_i,
	input  logic [IQ_DATA_W-1:0]           reg_wdata_i,
	output logic [IQ_DATA_W-1:0]           reg_rdata_o
);

	localparam int unsigned CNT_W = $clog2(FETCH_WIDTH * DEPTH + 1);

	instr_entry_t [FETCH_WIDTH-1:0] push_data;
	instr_entry_t [FETCH_WIDTH-1:0] pop_data;
	logic [IDX_W-1:0]               push_num;
	logic [IDX_W-1:0]               pop_num;
	logic [CNT_W-1:0]               count;
	iq_cfg_t                        cfg;

	fetch_packer #(
		.FETCH_WIDTH    ( FETCH_WIDTH ),
		.DEPTH          ( DEPTH       )
	) u_packer (
		.fetch_bundle_i ( fetch_bundle_i ),
		.fetch_mask_i   ( fetch_mask_i   ),
		.fetch_valid_i  ( fetch_valid_i  ),
		.count_i        ( count          ),
		.fetch_ready_o  ( fetch_ready_o  ),
		.push_data_o    ( push_data      ),
		.push_num_o     ( push_num       )
	);

	multi_queue #(
		.FETCH_WIDTH ( FETCH_WIDTH   ),
		.DEPTH       ( DEPTH         ),
		.dtype       ( instr_entry_t )
	) u_queue (
		.clk         ( clk       ),
		.rst_n       ( rst_n     ),
		.flush_i     ( cfg.flush ),
		.push_data_i ( push_data ),
		.push_num_i  ( push_num  ),
		.pop_data_o  ( pop_data  ),
		.pop_num_i   ( pop_num   ),
		.count_o     ( count     )
	);

	decode_dispatch #(
		.FETCH_WIDTH  ( FETCH_WIDTH ),
		.DEPTH        ( DEPTH       )
	) u_dispatch (
		.pop_data_i   ( pop_data     ),
		.count_i      ( count        ),
		.cfg_i        ( cfg          ),
		.dec_take_i   ( dec_take_i   ),
		.dec_bundle_o ( dec_bundle_o ),
		.dec_valid_o  ( dec_valid_o  ),
		.pop_num_o    ( pop_num      )
	);

	iq_regs #(
		.FETCH_WIDTH ( FETCH_WIDTH ),
		.DEPTH       ( DEPTH       )
	) u_regs (
		.clk         ( clk         ),
		.rst_n       ( rst_n       ),
		.reg_we_i    ( reg_we_i    ),
		.reg_addr_i  ( reg_addr_i  ),
		.reg_wdata_i ( reg_wdata_i ),
		.reg_rdata_o ( reg_rdata_o ),
		.flush_i     ( flush_i     ),
		.count_i     ( count       ),
		.cfg_o       ( cfg         )
	);

endmodule

//--- verif/tb_instr_buffer.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_instr_buffer import instr_pkg::*, iq_csr_pkg::*; ();

	localparam int          CLK_PERIOD = 40;
	localparam int unsigned FW         = `IQ_FETCH_WIDTH;
	localparam int unsigned DEPTH      = `IQ_DEPTH;
	localparam int unsigned CAP        = FW * DEPTH;
	localparam int unsigned IDX_W      = $clog2(FW + 1);

	// cycle budget of each test including its drain
	localparam int T_RESET  = 8;
	localparam int T_RANDOM = 300 + CAP + 8;
	localparam int T_FILL   = 2 * CAP + 20;
	localparam int T_LIMIT  = 110 + CAP + 10;
	localparam int T_STATUS = 40 + CAP + 8;
	localparam int T_FLUSH  = 40 + CAP + 10;
	localparam int BUDGET   = 4 + T_RESET + T_RANDOM + T_FILL + T_LIMIT + T_STATUS + T_FLUSH;
	localparam int WATCHDOG_CYCLES = (BUDGET * 3) / 2;

	logic                  clk;
	logic                  rst_n;
	logic                  flush_i;
	instr_entry_t [FW-1:0] fetch_bundle_i;
	logic [FW-1:0]         fetch_mask_i;
	logic                  fetch_valid_i;
	logic                  fetch_ready_o;
	instr_entry_t [FW-1:0] dec_bundle_o;
	logic [FW-1:0]         dec_valid_o;
	logic [IDX_W-1:0]      dec_take_i;
	logic                  reg_we_i;
	logic [IQ_ADDR_W-1:0]  reg_addr_i;
	logic [IQ_DATA_W-1:0]  reg_wdata_i;
	logic [IQ_DATA_W-1:0]  reg_rdata_o;

	// reference model state
	instr_entry_t          model_q [$];
	int                    model_cnt;
	int                    limit_m;
	logic                  flush_pend;  // ctrl flush lands one edge later
	instr_entry_t [FW-1:0] exp_head;
	logic                  data_ok;

	int          err_cnt;
	int          tests_run;
	int          tests_failed;
	logic [31:0] rng;
	logic [31:0] pc_next;

	instr_buffer_top #(
		.FETCH_WIDTH    ( FW    ),
		.DEPTH          ( DEPTH )
	) DUT (
		.clk            ( clk            ),
		.rst_n          ( rst_n          ),
		.flush_i        ( flush_i        ),
		.fetch_bundle_i ( fetch_bundle_i ),
		.fetch_mask_i   ( fetch_mask_i   ),
		.fetch_valid_i  ( fetch_valid_i  ),
		.fetch_ready_o  ( fetch_ready_o  ),
		.dec_bundle_o   ( dec_bundle_o   ),
		.dec_valid_o    ( dec_valid_o    ),
		.dec_take_i     ( dec_take_i     ),
		.reg_we_i       ( reg_we_i       ),
		.reg_addr_i     ( reg_addr_i     ),
		.reg_wdata_i    ( reg_wdata_i    ),
		.reg_rdata_o    ( reg_rdata_o    )
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] rand_next();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// entries decode may see with limit 0 standing for the whole width
	function automatic int exp_offer(input int limit, input int cnt);
		int lim;
		lim = (limit == 0) ? FW : limit;
		return (cnt < lim) ? cnt : lim;
	endfunction

	function automatic logic [FW-1:0] low_mask(input int n);
		return FW'((1 << n) - 1);
	endfunction

	task automatic log_error(input string msg);
		err_cnt++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// model follows the DUT handshakes as sampled at the edge
	always @(posedge clk or negedge rst_n) begin
		int n_pop;
		if (!rst_n) begin
			model_q.delete();
			limit_m    = 0;
			flush_pend = 1'b0;
		end else begin
			n_pop = $countones(dec_valid_o);
			if (dec_take_i < n_pop) begin
				n_pop = dec_take_i;
			end
			if (flush_i || flush_pend) begin
				model_q.delete();  // same-cycle push is dropped too
			end else begin
				for (int i = 0; i < n_pop && model_q.size() > 0; i++) begin
					void'(model_q.pop_front());
				end
				if (fetch_valid_i && fetch_ready_o) begin
					for (int i = 0; i < FW; i++) begin
						if (fetch_mask_i[i]) begin
							model_q.push_back(fetch_bundle_i[i]);
						end
					end
				end
			end
			flush_pend = 1'b0;
			if (reg_we_i && reg_addr_i == IQ_ADDR_CTRL) begin
				limit_m    = reg_wdata_i[IQ_LIMIT_W-1:0];
				flush_pend = reg_wdata_i[IQ_CTRL_FLUSH_BIT];
			end
		end
		model_cnt = model_q.size();
		for (int i = 0; i < FW; i++) begin
			exp_head[i] = (i < model_cnt) ? model_q[i] : '0;
		end
	end

	always_comb begin
		data_ok = 1'b1;
		for (int i = 0; i < FW; i++) begin
			if (dec_valid_o[i] && dec_bundle_o[i] !== exp_head[i]) begin
				data_ok = 1'b0;
			end
		end
	end

	a_order: assert property (@(posedge clk) disable iff (!rst_n) data_ok)
		else log_error("offered entry differs from model order");

	a_offer: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid_o == low_mask(exp_offer(limit_m, model_cnt)))
		else log_error($sformatf("dec_valid_o %b, model count %0d limit %0d",
			$sampled(dec_valid_o), $sampled(model_cnt), $sampled(limit_m)));

	// ready only when the whole bundle fits
	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_ready_o == ((model_cnt + $countones(fetch_mask_i)) <= CAP))
		else log_error($sformatf("fetch_ready_o %b with model count %0d",
			$sampled(fetch_ready_o), $sampled(model_cnt)));

	a_status: assert property (@(posedge clk) disable iff (!rst_n)
		reg_addr_i == IQ_ADDR_STATUS |-> reg_rdata_o == IQ_DATA_W'(model_cnt))
		else log_error($sformatf("STATUS read %0d, expected %0d",
			$sampled(reg_rdata_o), $sampled(model_cnt)));

	a_flush_pin: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> dec_valid_o == '0)
		else log_error("entries offered in the cycle after flush_i");

	a_flush_reg: assert property (@(posedge clk) disable iff (!rst_n)
		reg_we_i && reg_addr_i == IQ_ADDR_CTRL && reg_wdata_i[IQ_CTRL_FLUSH_BIT]
		|-> ##2 dec_valid_o == '0)
		else log_error("entries offered two cycles after a CTRL flush");

	task automatic drive(input logic valid, input logic [FW-1:0] mask, input int take);
		@(negedge clk);
		for (int i = 0; i < FW; i++) begin
			fetch_bundle_i[i].pc         = pc_next + 32'(4 * i);
			fetch_bundle_i[i].instr      = rand_next();
			fetch_bundle_i[i].pred_taken = 1'(rand_next() >> 7);
		end
		pc_next       = pc_next + 32'(4 * FW);
		fetch_valid_i = valid;
		fetch_mask_i  = mask;
		dec_take_i    = IDX_W'(take);
	endtask

	task automatic settle();
		#(CLK_PERIOD / 4);  // mid low phase where outputs are stable
	endtask

	task automatic random_traffic(input int cycles, input int max_take);
		logic [31:0] r;
		for (int c = 0; c < cycles; c++) begin
			r = rand_next();
			drive(r[2:0] != 3'd0, FW'(r >> 8), int'(r[31:16] % (max_take + 1)));
		end
	endtask

	task automatic write_ctrl(input logic [31:0] data);
		@(negedge clk);
		fetch_valid_i = 1'b0;
		dec_take_i    = '0;
		reg_we_i      = 1'b1;
		reg_addr_i    = IQ_ADDR_CTRL;
		reg_wdata_i   = data;
		@(negedge clk);
		reg_we_i      = 1'b0;
		reg_addr_i    = IQ_ADDR_STATUS;
	endtask

	task automatic drain(input int bound);
		int c;
		c = 0;
		drive(1'b0, '0, FW);
		settle();
		while (dec_valid_o != '0 && c < bound) begin
			drive(1'b0, '0, FW);
			settle();
			c++;
		end
		if (dec_valid_o != '0) begin
			err_cnt++;
			$display("drain: queue still offers entries after %0d cycles", bound);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		@(negedge clk);  // let the last edge's checks fire
		tests_run++;
		if (err_cnt != errs_before) begin
			tests_failed++;
		end
		$display("test %-14s %s, %0d errors", name,
			(err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
	endtask

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog: run not finished after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int            errs;
		int            c;
		logic [FW-1:0] m;
		logic          full_seen;

		rng            = 32'h0ef216a0;
		pc_next        = 32'h8000_0000;
		err_cnt        = 0;
		tests_run      = 0;
		tests_failed   = 0;
		rst_n          = 1'b0;
		flush_i        = 1'b0;
		fetch_bundle_i = '0;
		fetch_mask_i   = '0;
		fetch_valid_i  = 1'b0;
		dec_take_i     = '0;
		reg_we_i       = 1'b0;
		reg_addr_i     = IQ_ADDR_STATUS;
		reg_wdata_i    = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		errs = err_cnt;
		repeat (T_RESET - 2) drive(1'b0, '0, 0);
		finish_test("reset_state", errs);

		errs = err_cnt;
		random_traffic(300, FW);
		drain(CAP + 4);
		finish_test("random_order", errs);

		// fill with decode stalled until fetch is refused
		errs      = err_cnt;
		c         = 0;
		full_seen = 1'b0;
		while (!full_seen && c < CAP + 4) begin
			m = FW'(rand_next());
			if (m == '0) begin
				m = '1;
			end
			drive(1'b1, m, 0);
			settle();
			full_seen = !fetch_ready_o;
			c++;
		end
		if (!full_seen) begin
			err_cnt++;
			$display("fill: fetch_ready_o never dropped in %0d cycles", CAP + 4);
		end
		random_traffic(6, 0);  // smaller masks probe the boundary
		drain(CAP + 4);
		finish_test("fill_stall", errs);

		errs = err_cnt;
		for (int lim = 1; lim <= FW + 1; lim++) begin
			write_ctrl(32'(lim % (FW + 1)));  // ends on 0
			random_traffic(20, FW);
		end
		drain(CAP + 4);
		finish_test("issue_limit", errs);

		errs = err_cnt;
		random_traffic(40, 1);
		drain(CAP + 4);
		finish_test("status_read", errs);

		errs = err_cnt;
		random_traffic(10, 0);
		drive(1'b1, '1, FW);
		flush_i = 1'b1;
		drive(1'b1, '1, 0);
		flush_i = 1'b0;
		random_traffic(10, 0);
		write_ctrl(32'h8000_0000);
		random_traffic(10, 1);
		drain(CAP + 4);
		finish_test("flush", errs);

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+common
common/instr_pkg.sv
common/iq_csr_pkg.sv
rtl/fifo_v3.sv
instr_queue/multi_queue.sv
instr_queue/iq_regs.sv
rtl/fetch_packer.sv
rtl/decode_dispatch.sv
rtl/instr_buffer_top.sv
verif/tb_instr_buffer.sv
